// File: hw/mem_ctrl_defs.svh
`ifndef MEM_CTRL_DEFS_SVH
`define MEM_CTRL_DEFS_SVH

// memory map of the data port
// pages below the mmio page go to shared ram
// pages above it are unmapped
`define MC_MMIO_PAGE 20'haaaaa

// display and led register offsets in the mmio page
`define MC_OFF_DISP_EN 12'h004
`define MC_OFF_DISP_DATA 12'h008
`define MC_OFF_LED 12'h00c

// uart offsets
// data reads pop the rx fifo and writes push the tx fifo
`define MC_OFF_UART_DATA 12'h400
// status has tx_full in bit 1 and rx_present in bit 0
`define MC_OFF_UART_STAT 12'h404

// ram word address width
// 10 gives 1024 words of 32 bits
// ram sees byte address bits [MC_RAM_AW+1:2]
`define MC_RAM_AW 10

`endif

// File: hw/mem_ctrl_pkg.sv
`default_nettype none

package mem_ctrl_pkg;

`include "mem_ctrl_defs.svh"

    // data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] byte_en_t;

    // byte address split into page and offset
    typedef logic [19:0] page_t;
    typedef logic [11:0] offset_t;

    // word index into shared ram
    typedef logic [`MC_RAM_AW-1:0] ram_addr_t;

    // mmio payloads
    typedef logic [15:0] led_t;
    typedef logic [7:0] uart_byte_t;

    // address region of a data access
    typedef enum logic [1:0] {
        rgn_ram,
        rgn_mmio,
        rgn_unmapped
    } region_t;

    // four-phase handshake fsm
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait_resp,
        st_hold_ack
    } hs_state_t;

endpackage

`default_nettype wire

// File: hw/req_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defs.svh"

module req_decode_stage
    import mem_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  logic      we,
    input  addr_t     addr,
    input  byte_en_t  be,
    input  word_t     wdata,
    input  logic      resp_valid,
    input  word_t     resp_data,
    output logic      ack,
    output word_t     rdata,
    output logic      acc_valid,
    output logic      acc_we,
    output region_t   acc_region,
    output ram_addr_t acc_ram_addr,
    output offset_t   acc_offset,
    output byte_en_t  acc_lane_en,
    output byte_en_t  acc_be,
    output word_t     acc_wdata
);

    hs_state_t state;
    page_t     page;
    region_t   region;
    byte_en_t  lane_en;
    word_t     packed_wdata;

    // move wdata into the lanes named by be
    // byte patterns take byte 0, halfword patterns the low halfword
    function automatic word_t pack_wdata(input byte_en_t be_in, input word_t w);
        case (be_in)
            4'b0001: pack_wdata = {24'h0, w[7:0]};
            4'b0010: pack_wdata = {16'h0, w[7:0], 8'h0};
            4'b0100: pack_wdata = {8'h0, w[7:0], 16'h0};
            4'b1000: pack_wdata = {w[7:0], 24'h0};
            4'b0011: pack_wdata = {16'h0, w[15:0]};
            4'b0110: pack_wdata = {8'h0, w[15:0], 8'h0};
            4'b1100: pack_wdata = {w[15:0], 16'h0};
            default: pack_wdata = w;
        endcase
    endfunction

    assign page = addr[31:12];

    // region by page compare
    always_comb begin
        if (page < `MC_MMIO_PAGE) begin
            region = rgn_ram;
        end else if (page == `MC_MMIO_PAGE) begin
            region = rgn_mmio;
        end else begin
            region = rgn_unmapped;
        end
    end

    // lanes only reach the ram on ram writes
    assign lane_en = (region == rgn_ram && we) ? be : 4'b0000;
    assign packed_wdata = pack_wdata(be, wdata);

    // one access cycle right after the req edge
    assign acc_valid = (state == st_issue);

    // handshake fsm
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    state <= st_wait_resp;
                end
                st_wait_resp: begin
                    if (resp_valid) begin
                        state <= st_hold_ack;
                        ack <= 1'b1;
                    end
                end
                st_hold_ack: begin
                    // hold ack until the cpu lets go of req
                    if (!req) begin
                        state <= st_idle;
                        ack <= 1'b0;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // access fields latched on the accepting edge
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            acc_we <= we;
            acc_region <= region;
            acc_ram_addr <= addr[$bits(ram_addr_t)+1:2];
            acc_offset <= addr[11:0];
            acc_lane_en <= lane_en;
            acc_be <= be;
            acc_wdata <= packed_wdata;
        end
    end

    // response captured together with ack
    always_ff @(posedge clk) begin
        if (state == st_wait_resp && resp_valid) begin
            rdata <= resp_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/shared_ram.sv
`timescale 1ns/1ps
`default_nettype none

module shared_ram
    import mem_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      fetch_en,
    input  ram_addr_t fetch_addr,
    input  logic      acc_valid,
    input  region_t   acc_region,
    input  byte_en_t  acc_lane_en,
    input  ram_addr_t acc_ram_addr,
    input  word_t     acc_wdata,
    output word_t     fetch_data,
    output word_t     ram_rdata
);

    localparam int DEPTH = 2 ** $bits(ram_addr_t);

    word_t mem [0:DEPTH-1];
    logic  port_b_en;

    // data port only for ram region accesses
    assign port_b_en = acc_valid && (acc_region == rgn_ram);

    // port a, instruction fetch
    // one cycle latency, new address every cycle
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data <= mem[fetch_addr];
        end
    end

    // port b, data access
    // read-first, old word comes out while lanes are written
    always_ff @(posedge clk) begin
        if (port_b_en) begin
            ram_rdata <= mem[acc_ram_addr];
            for (int i = 0; i < 4; i++) begin
                if (acc_lane_en[i]) begin
                    mem[acc_ram_addr][8*i +: 8] <= acc_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defs.svh"

module mmio_regs
    import mem_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       acc_valid,
    input  logic       acc_we,
    input  region_t    acc_region,
    input  offset_t    acc_offset,
    input  word_t      acc_wdata,
    input  uart_byte_t uart_rx_data,
    input  logic       uart_rx_present,
    input  logic       uart_tx_full,
    output word_t      mmio_rdata,
    output logic       disp_en,
    output word_t      disp_data,
    output led_t       led,
    output logic       uart_tx_wen,
    output uart_byte_t uart_tx_data,
    output logic       uart_rx_ren
);

    logic hit;
    logic wr_hit;
    logic rd_hit;
    logic uart_data_sel;

    // mmio page access this cycle
    assign hit = acc_valid && (acc_region == rgn_mmio);
    assign wr_hit = hit && acc_we;
    assign rd_hit = hit && !acc_we;
    assign uart_data_sel = (acc_offset == `MC_OFF_UART_DATA);

    // display and led registers
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_en <= 1'b0;
            disp_data <= '0;
            led <= '0;
        end else if (wr_hit) begin
            case (acc_offset)
                `MC_OFF_DISP_EN: disp_en <= acc_wdata[0];
                `MC_OFF_DISP_DATA: disp_data <= acc_wdata;
                `MC_OFF_LED: led <= acc_wdata[15:0];
                default: ;
            endcase
        end
    end

    // uart strobes, one cycle each
    always_ff @(posedge clk) begin
        if (rst) begin
            uart_tx_wen <= 1'b0;
            uart_rx_ren <= 1'b0;
        end else begin
            uart_tx_wen <= wr_hit && uart_data_sel;
            uart_rx_ren <= rd_hit && uart_data_sel;
        end
    end

    // tx byte goes out with the strobe
    always_ff @(posedge clk) begin
        if (wr_hit && uart_data_sel) begin
            uart_tx_data <= acc_wdata[7:0];
        end
    end

    // registered read mux
    // rx byte sampled on the same edge as the pop strobe
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            case (acc_offset)
                `MC_OFF_UART_DATA: mmio_rdata <= {24'h0, uart_rx_data};
                `MC_OFF_UART_STAT: mmio_rdata <= {30'h0, uart_tx_full, uart_rx_present};
                default: mmio_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/read_align_stage.sv
`timescale 1ns/1ps
`default_nettype none

module read_align_stage
    import mem_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     acc_valid,
    input  region_t  acc_region,
    input  byte_en_t acc_be,
    input  word_t    ram_rdata,
    input  word_t    mmio_rdata,
    output logic     resp_valid,
    output word_t    resp_data
);

    logic     tag_valid;
    region_t  tag_region;
    byte_en_t tag_be;
    word_t    ram_aligned;

    // pull the lanes named by be down to bit 0, zero-extended
    // same pattern set as write packing
    function automatic word_t extract_lanes(input byte_en_t be_in, input word_t w);
        case (be_in)
            4'b0001: extract_lanes = {24'h0, w[7:0]};
            4'b0010: extract_lanes = {24'h0, w[15:8]};
            4'b0100: extract_lanes = {24'h0, w[23:16]};
            4'b1000: extract_lanes = {24'h0, w[31:24]};
            4'b0011: extract_lanes = {16'h0, w[15:0]};
            4'b0110: extract_lanes = {16'h0, w[23:8]};
            4'b1100: extract_lanes = {16'h0, w[31:16]};
            default: extract_lanes = w;
        endcase
    endfunction

    // tag follows the access into the ram/mmio stage
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            tag_region <= acc_region;
            tag_be <= acc_be;
        end
    end

    assign ram_aligned = extract_lanes(tag_be, ram_rdata);

    // response pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= tag_valid;
        end
    end

    // source select, unmapped reads give zero
    always_ff @(posedge clk) begin
        if (tag_valid) begin
            case (tag_region)
                rgn_ram: resp_data <= ram_aligned;
                rgn_mmio: resp_data <= mmio_rdata;
                default: resp_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top
    import mem_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  logic       we,
    input  addr_t      addr,
    input  byte_en_t   be,
    input  word_t      wdata,
    input  logic       fetch_en,
    input  addr_t      fetch_addr,
    input  uart_byte_t uart_rx_data,
    input  logic       uart_rx_present,
    input  logic       uart_tx_full,
    output logic       ack,
    output word_t      rdata,
    output word_t      fetch_data,
    output logic       disp_en,
    output word_t      disp_data,
    output led_t       led,
    output logic       uart_tx_wen,
    output uart_byte_t uart_tx_data,
    output logic       uart_rx_ren
);

    // access stage bundle
    logic      acc_valid;
    logic      acc_we;
    region_t   acc_region;
    ram_addr_t acc_ram_addr;
    offset_t   acc_offset;
    byte_en_t  acc_lane_en;
    byte_en_t  acc_be;
    word_t     acc_wdata;

    // access results and response
    word_t     ram_rdata;
    word_t     mmio_rdata;
    logic      resp_valid;
    word_t     resp_data;

    // fetch byte address to word index
    ram_addr_t fetch_word;

    assign fetch_word = fetch_addr[$bits(ram_addr_t)+1:2];

    req_decode_stage req_decode_i (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .be(be),
        .wdata(wdata), .resp_valid(resp_valid), .resp_data(resp_data),
        .ack(ack), .rdata(rdata), .acc_valid(acc_valid), .acc_we(acc_we),
        .acc_region(acc_region), .acc_ram_addr(acc_ram_addr),
        .acc_offset(acc_offset), .acc_lane_en(acc_lane_en), .acc_be(acc_be),
        .acc_wdata(acc_wdata)
    );

    shared_ram shared_ram_i (
        .clk(clk), .fetch_en(fetch_en), .fetch_addr(fetch_word),
        .acc_valid(acc_valid), .acc_region(acc_region), .acc_lane_en(acc_lane_en),
        .acc_ram_addr(acc_ram_addr), .acc_wdata(acc_wdata),
        .fetch_data(fetch_data), .ram_rdata(ram_rdata)
    );

    mmio_regs mmio_regs_i (
        .clk(clk), .rst(rst), .acc_valid(acc_valid), .acc_we(acc_we),
        .acc_region(acc_region), .acc_offset(acc_offset), .acc_wdata(acc_wdata),
        .uart_rx_data(uart_rx_data), .uart_rx_present(uart_rx_present),
        .uart_tx_full(uart_tx_full), .mmio_rdata(mmio_rdata), .disp_en(disp_en),
        .disp_data(disp_data), .led(led), .uart_tx_wen(uart_tx_wen),
        .uart_tx_data(uart_tx_data), .uart_rx_ren(uart_rx_ren)
    );

    read_align_stage read_align_i (
        .clk(clk), .rst(rst), .acc_valid(acc_valid), .acc_region(acc_region),
        .acc_be(acc_be), .ram_rdata(ram_rdata), .mmio_rdata(mmio_rdata),
        .resp_valid(resp_valid), .resp_data(resp_data)
    );

endmodule

`default_nettype wire

// File: verification/mem_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defs.svh"

module mem_ctrl_tb
    import mem_ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    // ack is registered four edges after the edge that raises req
    localparam int ACK_EDGES = 4;
    localparam int N_WORDS = 16;
    localparam int RAM_WORDS = 1 << `MC_RAM_AW;
    // bus transfers of all tests plus slack for reset and fetch
    localparam int NUM_TXN = 2 * N_WORDS + 4 * 7 + 9 + 7 + 8;
    localparam int WATCHDOG_NS = NUM_TXN * 12 * CLK_PERIOD;

    logic clk, rst, req, we, fetch_en, uart_rx_present, uart_tx_full;
    addr_t addr, fetch_addr;
    byte_en_t be;
    word_t wdata, rdata, fetch_data, disp_data;
    logic ack, disp_en, uart_tx_wen, uart_rx_ren;
    led_t led;
    uart_byte_t uart_tx_data, tx_last;
    uart_byte_t uart_rx_data = 8'h5a;
    int tx_pushes = 0;
    int rx_pops = 0;
    word_t ram_model [0:RAM_WORDS-1];
    integer seed = 32'ha7df8b65;
    string test_name;

    mem_ctrl_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // uart model
    // logs pushed tx bytes and moves on to the next rx byte at each pop
    always @(posedge clk) begin
        if (uart_tx_wen) begin
            tx_pushes <= tx_pushes + 1;
            tx_last <= uart_tx_data;
        end
        if (uart_rx_ren) begin
            rx_pops <= rx_pops + 1;
            uart_rx_data <= uart_rx_data + 8'h33;
        end
    end

    task automatic fail_now();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error %s, %s: expected %h actual %h", test_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_led(input string what, input led_t exp, input led_t act);
        if (act !== exp) begin
            $display("error %s, %s: expected %h actual %h", test_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_byte(input string what, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            $display("error %s, %s: expected %h actual %h", test_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s, %s: expected %b actual %b", test_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("error %s, %s: expected %0d actual %0d", test_name, what, exp, act);
            fail_now();
        end
    endtask

    // ram word that a byte address lands on
    function automatic ram_addr_t word_index(input addr_t a);
        return a[`MC_RAM_AW+1:2];
    endfunction

    // bit offset of the low lane for byte and halfword patterns
    // full words stay in place
    function automatic int lane_shift(input byte_en_t b);
        if (!(b inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100})) begin
            return 0;
        end
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                return 8 * i;
            end
        end
        return 0;
    endfunction

    // ram reference shifts the low data bits up into the enabled lanes
    task automatic model_write(input addr_t a, input byte_en_t b, input word_t d);
        word_t placed;
        placed = d << lane_shift(b);
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                ram_model[word_index(a)][8*i +: 8] = placed[8*i +: 8];
            end
        end
    endtask

    // enabled lanes moved down to bit 0 with the rest zero
    function automatic word_t expected_read(input addr_t a, input byte_en_t b);
        word_t mask;
        mask = 32'h0;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                mask[8*i +: 8] = 8'hff;
            end
        end
        return (ram_model[word_index(a)] & mask) >> lane_shift(b);
    endfunction

    function automatic addr_t mmio_addr(input offset_t off);
        return {`MC_MMIO_PAGE, off};
    endfunction

    // one four-phase transfer with ack timing checks
    task automatic bus_access(input logic w, input addr_t a, input byte_en_t b,
                              input word_t d, output word_t rd);
        int edges;
        int hold;
        edges = 0;
        hold = {$random(seed)} % 4;
        @(posedge clk);
        req <= 1'b1;
        we <= w;
        addr <= a;
        be <= b;
        wdata <= d;
        // count edges until ack with an upper bound
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack && edges < 2 * ACK_EDGES);
        check_count("edges from req to ack", ACK_EDGES, edges);
        rd = rdata;
        // ack must stay up for a slow cpu
        repeat (hold) begin
            @(negedge clk);
            check_bit("ack while req held", 1'b1, ack);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_bit("ack before req sampled low", 1'b1, ack);
        @(negedge clk);
        check_bit("ack after req release", 1'b0, ack);
    endtask

    task automatic ram_write(input addr_t a, input byte_en_t b, input word_t d);
        word_t rd;
        bus_access(1'b1, a, b, d, rd);
        model_write(a, b, d);
    endtask

    // reads drive random wdata that must not land anywhere
    task automatic ram_read_check(input string what, input addr_t a, input byte_en_t b);
        word_t rd;
        bus_access(1'b0, a, b, $random(seed), rd);
        check_word(what, expected_read(a, b), rd);
    endtask

    task automatic test_reset();
        test_name = "reset";
        @(negedge clk);
        check_bit("ack", 1'b0, ack);
        check_bit("uart_tx_wen", 1'b0, uart_tx_wen);
        check_bit("uart_rx_ren", 1'b0, uart_rx_ren);
        check_bit("disp_en", 1'b0, disp_en);
        check_led("led", 16'h0000, led);
        check_word("disp_data", 32'h0, disp_data);
    endtask

    // consecutive words from byte address 1000 hex
    task automatic test_word_access();
        test_name = "word access";
        for (int i = 0; i < N_WORDS; i++) begin
            ram_write(32'h0000_1000 + 4 * i, 4'b1111, $random(seed));
        end
        for (int i = N_WORDS - 1; i >= 0; i--) begin
            ram_read_check("word readback", 32'h0000_1000 + 4 * i, 4'b1111);
        end
    endtask

    task automatic test_sub_word();
        byte_en_t pats [0:6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b0110, 4'b1100};
        addr_t a;
        test_name = "sub-word access";
        for (int k = 0; k < 7; k++) begin
            a = 32'h0000_0400 + 4 * k;
            ram_write(a, 4'b1111, $random(seed));
            ram_write(a, pats[k], $random(seed));
            ram_read_check("full word after lane write", a, 4'b1111);
            ram_read_check("lane read", a, pats[k]);
        end
    endtask

    // new fetch address every edge with data one edge later
    task automatic test_fetch();
        test_name = "fetch port";
        for (int i = 0; i <= N_WORDS; i++) begin
            @(posedge clk);
            fetch_en <= (i < N_WORDS);
            fetch_addr <= 32'h0000_1000 + 4 * i;
            @(negedge clk);
            if (i > 0) begin
                check_word("fetch data", ram_model[word_index(32'h0000_1000 + 4 * (i - 1))],
                           fetch_data);
            end
        end
    endtask

    task automatic test_mmio();
        word_t d;
        word_t rd;
        uart_byte_t rx_byte;
        test_name = "mmio registers";
        d = $random(seed);
        bus_access(1'b1, mmio_addr(`MC_OFF_DISP_EN), 4'b1111, d | 32'h1, rd);
        check_bit("disp_en set", 1'b1, disp_en);
        bus_access(1'b1, mmio_addr(`MC_OFF_DISP_EN), 4'b1111, d & ~32'h1, rd);
        check_bit("disp_en cleared", 1'b0, disp_en);
        d = $random(seed);
        bus_access(1'b1, mmio_addr(`MC_OFF_DISP_DATA), 4'b1111, d, rd);
        check_word("disp_data", d, disp_data);
        d = $random(seed);
        bus_access(1'b1, mmio_addr(`MC_OFF_LED), 4'b1111, d, rd);
        check_led("led", d[15:0], led);
        // only the uart offsets read back
        bus_access(1'b0, mmio_addr(`MC_OFF_LED), 4'b1111, 32'h0, rd);
        check_word("led offset read", 32'h0, rd);
        d = $random(seed);
        bus_access(1'b1, mmio_addr(`MC_OFF_UART_DATA), 4'b1111, d, rd);
        check_count("uart_tx_wen pulses", 1, tx_pushes);
        check_byte("uart tx byte", d[7:0], tx_last);
        rx_byte = uart_rx_data;
        bus_access(1'b0, mmio_addr(`MC_OFF_UART_DATA), 4'b1111, 32'h0, rd);
        check_count("uart_rx_ren pulses", 1, rx_pops);
        check_word("uart rx read", {24'h0, rx_byte}, rd);
        // status both ways round without an rx pop
        for (int s = 0; s < 2; s++) begin
            @(posedge clk);
            uart_tx_full <= (s == 0);
            uart_rx_present <= (s != 0);
            bus_access(1'b0, mmio_addr(`MC_OFF_UART_STAT), 4'b1111, 32'h0, rd);
            check_word("uart status", {30'h0, s == 0, s != 0}, rd);
        end
        check_count("uart_rx_ren pulses after status", 1, rx_pops);
    endtask

    task automatic test_unmapped();
        word_t rd;
        test_name = "unmapped page";
        // same word index as the first word test entry
        bus_access(1'b1, 32'hb000_1000, 4'b1111, ~ram_model[word_index(32'h0000_1000)], rd);
        // words aliased by the unmapped and mmio writes
        for (int i = 0; i < 4; i++) begin
            ram_read_check("ram word behind other pages", 32'h0000_1000 + 4 * i, 4'b1111);
        end
        bus_access(1'b0, 32'hb000_1000, 4'b1111, 32'h0, rd);
        check_word("unmapped read", 32'h0, rd);
        bus_access(1'b0, 32'hffff_fffc, 4'b1111, 32'h0, rd);
        check_word("top of address space", 32'h0, rd);
    endtask

    initial begin
        rst <= 1'b1;
        req <= 1'b0;
        we <= 1'b0;
        addr <= '0;
        be <= '0;
        wdata <= '0;
        fetch_en <= 1'b0;
        fetch_addr <= '0;
        uart_rx_present <= 1'b0;
        uart_tx_full <= 1'b0;
        // reset values seen after the first reset edge
        @(posedge clk);
        test_reset();
        @(posedge clk);
        rst <= 1'b0;
        test_word_access();
        test_sub_word();
        test_fetch();
        test_mmio();
        test_unmapped();
        test_name = "whole run";
        check_count("uart_tx_wen pulses", 1, tx_pushes);
        check_count("uart_rx_ren pulses", 1, rx_pops);
        $display("TESTS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
        fail_now();
    end

endmodule

`default_nettype wire

// File: mem_ctrl_top.f
+incdir+hw
hw/mem_ctrl_pkg.sv
hw/req_decode_stage.sv
hw/shared_ram.sv
hw/mmio_regs.sv
hw/read_align_stage.sv
hw/mem_ctrl_top.sv
verification/mem_ctrl_tb.sv

// File: Makefile
# memory controller, lint and simulation with verilator

VERILATOR ?= verilator
FILELIST  ?= mem_ctrl_top.f
RTL_TOP   ?= mem_ctrl_top
TB_TOP    ?= mem_ctrl_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
